// File: Makefile
TOP := csma_ca_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(wildcard source/*.sv source/*.svh testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: source/backoff_ctrl.sv
// timer arithmetic wraps like the hardware it models; advances larger than the IFS are not caught
`timescale 1ns/1ps

`include "csma_settings.svh"

`default_nettype none

module backoff_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   reset_backoff,
    input  logic                   tsf_pulse_1m,
    input  logic                   ch_idle_final,
    input  logic                   high_trigger,
    input  logic                   retrans_trigger,
    input  logic                   quit_retrans,
    input  logic                   tx_bb_is_ongoing,
    input  logic                   ack_tx_flag,
    input  logic                   fcs_in_strobe,
    input  logic                   fcs_valid,
    input  logic                   difs_enable,
    input  logic                   eifs_enable,
    input  logic [4:0]             slot_time,
    input  logic [6:0]             sifs_time,
    input  logic [7:0]             difs_advance,
    input  logic [7:0]             backoff_advance,
    input  csma_pkg::cw_exp_t      cw_exp_used,
    input  csma_pkg::slot_cnt_t    slot_count,
    input  csma_pkg::wait_cnt_t    wait_count,
    input  logic                   wait_zero,
    input  csma_pkg::backoff_cnt_t backoff_count,
    input  logic                   backoff_zero,
    output logic                   wait_load,
    output csma_pkg::wait_cnt_t    wait_load_value,
    output logic                   wait_enable,
    output logic                   backoff_load,
    output csma_pkg::backoff_cnt_t backoff_load_value,
    output logic                   backoff_enable,
    output logic                   take_new_random,
    output logic                   backoff_done,
    output csma_pkg::cw_exp_t      cw_exp_log,
    output csma_pkg::slot_cnt_t    num_slot_random_log
);

    import csma_pkg::*;

    localparam int PROD_W = `CSMA_SLOTS_W + 5;

    backoff_state_t    state, state_next;
    logic              last_fcs_valid;
    wait_cnt_t         difs_time, eifs_time, ifs_time, ifs_wait, quit_wait;
    logic [PROD_W-1:0] slot_product;
    backoff_cnt_t      slot_backoff;
    logic              log_clear, log_capture;

    assign difs_time = difs_enable ?
                       wait_cnt_t'(sifs_time) + wait_cnt_t'({slot_time, 1'b0}) : '0;
    assign eifs_time = eifs_enable ?
                       wait_cnt_t'(sifs_time) + difs_time +
                       wait_cnt_t'(`CSMA_LONGEST_ACK_US) : '0;
    assign ifs_time  = last_fcs_valid ? difs_time : eifs_time;  // EIFS after a bad frame
    assign ifs_wait  = (ifs_time == '0) ? '0 : ifs_time - wait_cnt_t'(difs_advance);

    // on quit, keep whichever is shorter: leftover backoff or a fresh IFS
    assign quit_wait = (backoff_count > backoff_cnt_t'(ifs_time)) ?
                       ifs_wait : wait_cnt_t'(backoff_count);

    assign slot_product = slot_count * slot_time;
    assign slot_backoff = (slot_count == '0) ? '0 :
                          backoff_cnt_t'(slot_product - PROD_W'(backoff_advance));

    always_comb begin
        state_next         = state;
        wait_load          = 1'b0;
        wait_load_value    = '0;
        backoff_load       = 1'b0;
        backoff_load_value = '0;
        log_clear          = 1'b0;
        log_capture        = 1'b0;
        case (state)
            IDLE: begin
                backoff_load = 1'b1;
                log_clear    = high_trigger || quit_retrans;
                if (ch_idle_final) begin
                    if (high_trigger || quit_retrans || retrans_trigger) begin
                        state_next      = retrans_trigger && !(high_trigger || quit_retrans) ?
                                          WAIT_2 : WAIT_1;
                        wait_load       = 1'b1;
                        wait_load_value = ifs_wait;
                    end
                end else if (high_trigger || retrans_trigger || quit_retrans) begin
                    state_next = CH_BUSY;
                    wait_load  = 1'b1;  // wait cleared
                end
            end
            CH_BUSY: begin
                backoff_load = 1'b1;
                wait_load    = 1'b1;
                if (ch_idle_final) begin
                    wait_load_value = ifs_wait;
                    state_next      = WAIT_2;
                end
            end
            WAIT_1: begin
                backoff_load = 1'b1;
                log_clear    = 1'b1;
                if (!ch_idle_final) state_next = CH_BUSY;
                else if (wait_zero) state_next = WAIT_FOR_OWN;
            end
            WAIT_2: begin
                backoff_load = 1'b1;
                if (!ch_idle_final) begin
                    state_next = CH_BUSY;
                end else if (quit_retrans) begin
                    state_next = WAIT_1;  // new packet, skip the backoff
                end else if (wait_zero) begin
                    state_next         = RUN;
                    backoff_load_value = slot_backoff;
                    log_capture        = 1'b1;
                end
            end
            RUN: begin
                if (!ch_idle_final) begin
                    state_next = backoff_zero ? CH_BUSY : SUSPEND;
                end else if (quit_retrans) begin
                    state_next      = WAIT_1;
                    wait_load       = 1'b1;
                    wait_load_value = quit_wait;
                end else if (backoff_zero) begin
                    state_next = WAIT_FOR_OWN;
                end
            end
            SUSPEND: begin
                if (ch_idle_final) begin
                    state_next = quit_retrans ? WAIT_1 : RUN;
                    wait_load       = quit_retrans;
                    wait_load_value = quit_wait;
                end else if (quit_retrans) begin
                    state_next = CH_BUSY;
                    log_clear  = 1'b1;
                end
            end
            WAIT_FOR_OWN: begin
                // ACK going out means we still owe a backoff
                if (tx_bb_is_ongoing) state_next = ack_tx_flag ? CH_BUSY : IDLE;
            end
            default: state_next = IDLE;
        endcase
        if (reset_backoff) begin
            state_next         = IDLE;
            wait_load          = 1'b1;
            wait_load_value    = '0;
            backoff_load       = 1'b1;
            backoff_load_value = '0;
        end
    end

    assign wait_enable    = (state == WAIT_1) || (state == WAIT_2);
    assign backoff_enable = (state == RUN) && ch_idle_final;
    assign backoff_done   = (state == WAIT_FOR_OWN);

    always_ff @(posedge clk) begin
        if (!rstn || reset_backoff) begin
            state               <= IDLE;
            last_fcs_valid      <= 1'b0;
            take_new_random     <= 1'b0;
            cw_exp_log          <= '0;
            num_slot_random_log <= '0;
        end else begin
            state <= state_next;
            if (fcs_in_strobe) last_fcs_valid <= fcs_valid;
            // fresh number ready well before the wait expires
            take_new_random <= (state == WAIT_2) && tsf_pulse_1m &&
                               (wait_count == wait_cnt_t'(2));
            if (log_capture) begin
                cw_exp_log          <= cw_exp_used;
                num_slot_random_log <= slot_count;
            end else if (log_clear) begin
                cw_exp_log          <= '0;
                num_slot_random_log <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/csma_ca_top.sv
// timing inputs are in microseconds and must hold steady while a backoff is in progress
`timescale 1ns/1ps

`default_nettype none

module csma_ca_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tsf_pulse_1m,
    input  logic                pkt_header_valid,
    input  logic                pkt_header_valid_strobe,
    input  logic                fcs_in_strobe,
    input  logic                fcs_valid,
    input  logic                nav_enable,
    input  logic                difs_enable,
    input  logic                eifs_enable,
    input  csma_pkg::cw_exp_t   cw_exp_used,
    input  logic [4:0]          slot_time,
    input  logic [6:0]          sifs_time,
    input  logic [7:0]          difs_advance,
    input  logic [7:0]          backoff_advance,
    input  logic                addr1_valid,
    input  csma_pkg::mac_addr_t addr1,
    input  csma_pkg::mac_addr_t self_mac_addr,
    input  logic                fc_di_valid,
    input  logic [15:0]         duration,
    input  logic                ch_idle,
    input  logic                retrans_trigger,
    input  logic                quit_retrans,
    input  logic                reset_backoff,
    input  logic                high_trigger,
    input  logic                tx_bb_is_ongoing,
    input  logic                ack_tx_flag,
    output logic                backoff_done,
    output csma_pkg::cw_exp_t   cw_exp_log,
    output csma_pkg::slot_cnt_t num_slot_random_log
);

    import csma_pkg::*;

    logic         ch_idle_final;
    logic         take_new_random;
    slot_cnt_t    slot_count;
    logic         wait_load, wait_enable, wait_zero;
    wait_cnt_t    wait_load_value, wait_count;
    logic         backoff_load, backoff_enable, backoff_zero;
    backoff_cnt_t backoff_load_value, backoff_count;

    nav_tracker u_nav (
        .clk, .rstn, .tsf_pulse_1m, .nav_enable, .ch_idle,
        .pkt_header_valid_strobe, .pkt_header_valid, .fc_di_valid, .duration,
        .addr1_valid, .addr1, .self_mac_addr, .fcs_in_strobe, .fcs_valid,
        .ch_idle_final
    );

    slot_randomizer u_rand (
        .clk, .rstn, .take_new_random, .cw_exp_used, .slot_count
    );

    // IFS wait timer
    usec_countdown #(.count_t(wait_cnt_t)) u_wait_timer (
        .clk, .rstn, .tsf_pulse_1m,
        .load(wait_load), .load_value(wait_load_value), .enable(wait_enable),
        .count(wait_count), .zero(wait_zero)
    );

    usec_countdown #(.count_t(backoff_cnt_t)) u_backoff_timer (
        .clk, .rstn, .tsf_pulse_1m,
        .load(backoff_load), .load_value(backoff_load_value), .enable(backoff_enable),
        .count(backoff_count), .zero(backoff_zero)
    );

    backoff_ctrl u_ctrl (
        .clk, .rstn, .reset_backoff, .tsf_pulse_1m, .ch_idle_final,
        .high_trigger, .retrans_trigger, .quit_retrans, .tx_bb_is_ongoing, .ack_tx_flag,
        .fcs_in_strobe, .fcs_valid, .difs_enable, .eifs_enable,
        .slot_time, .sifs_time, .difs_advance, .backoff_advance, .cw_exp_used,
        .slot_count, .wait_count, .wait_zero, .backoff_count, .backoff_zero,
        .wait_load, .wait_load_value, .wait_enable,
        .backoff_load, .backoff_load_value, .backoff_enable,
        .take_new_random, .backoff_done, .cw_exp_log, .num_slot_random_log
    );

endmodule

`default_nettype wire

// File: source/csma_pkg.sv
// types only; widths come from csma_settings.svh, so compile this before any module
`include "csma_settings.svh"

`default_nettype none

package csma_pkg;

    typedef logic [`CSMA_NAV_W-1:0]      nav_t;          // microseconds
    typedef logic [`CSMA_WAIT_W-1:0]     wait_cnt_t;
    typedef logic [`CSMA_BACKOFF_W-1:0]  backoff_cnt_t;
    typedef logic [`CSMA_SLOTS_W-1:0]    slot_cnt_t;
    typedef logic [`CSMA_CW_EXP_W-1:0]   cw_exp_t;
    typedef logic [`CSMA_MAC_ADDR_W-1:0] mac_addr_t;

    // virtual carrier sense, one pass per received frame
    typedef enum logic [1:0] {
        NAV_IDLE,
        NAV_WAIT_DURATION,
        NAV_CHECK_RA,
        NAV_UPDATE
    } nav_state_t;

    typedef enum logic [2:0] {
        IDLE,
        CH_BUSY,
        WAIT_1,         // IFS only, no backoff after it
        WAIT_2,         // IFS followed by random backoff
        RUN,
        SUSPEND,        // backoff frozen while medium busy
        WAIT_FOR_OWN
    } backoff_state_t;

endpackage

`default_nettype wire

// File: source/csma_settings.svh
// widths in bits, times in microseconds; the LFSR reset value must never be all ones
`ifndef CSMA_SETTINGS_SVH
`define CSMA_SETTINGS_SVH

`default_nettype none

// counter and field widths
`define CSMA_NAV_W          15
`define CSMA_WAIT_W         12
`define CSMA_BACKOFF_W      13
`define CSMA_SLOTS_W        10
`define CSMA_CW_EXP_W       4
`define CSMA_MAC_ADDR_W     48

`define CSMA_CW_EXP_MAX     10  // window tops out at 1023 slots

// fixed ACK airtime folded into EIFS
`define CSMA_LONGEST_ACK_US 44

`define CSMA_LFSR_INIT      32'h1020f0cb  // any value except 32'hffffffff

`default_nettype wire

`endif

// File: source/nav_tracker.sv
// NAV only from frames with a good FCS addressed elsewhere; PS-Poll and RTS timeout not handled
`timescale 1ns/1ps

`include "csma_settings.svh"

`default_nettype none

module nav_tracker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tsf_pulse_1m,
    input  logic                nav_enable,
    input  logic                ch_idle,
    input  logic                pkt_header_valid_strobe,
    input  logic                pkt_header_valid,
    input  logic                fc_di_valid,
    input  logic [15:0]         duration,
    input  logic                addr1_valid,
    input  csma_pkg::mac_addr_t addr1,
    input  csma_pkg::mac_addr_t self_mac_addr,
    input  logic                fcs_in_strobe,
    input  logic                fcs_valid,
    output logic                ch_idle_final
);

    import csma_pkg::*;

    nav_state_t nav_state;
    nav_t       nav;
    nav_t       nav_dur;
    logic       nav_raise;

    // bit 15 set means AID or reserved, no NAV meaning
    assign nav_dur = duration[15] ? '0 : nav_t'(duration[14:0]);

    // a new duration may only extend the current NAV
    assign nav_raise = (nav_state == NAV_UPDATE) && !pkt_header_valid_strobe &&
                       fcs_in_strobe && fcs_valid && (nav_dur > nav);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav <= '0;
        end else if (nav_raise) begin
            nav <= nav_dur;
        end else if (tsf_pulse_1m && (nav != '0)) begin
            nav <= nav - 1'b1;
        end
    end

    // header strobe restarts the walk, also recovers from a lost FCS strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav_state <= NAV_IDLE;
        end else if (pkt_header_valid_strobe) begin
            nav_state <= pkt_header_valid ? NAV_WAIT_DURATION : NAV_IDLE;
        end else begin
            case (nav_state)
                NAV_IDLE: begin
                    nav_state <= NAV_IDLE;  // parked until next header
                end
                NAV_WAIT_DURATION: begin
                    if (fc_di_valid && !duration[15]) begin
                        nav_state <= NAV_CHECK_RA;
                    end
                end
                NAV_CHECK_RA: begin
                    // frames for us never touch the NAV
                    if (addr1_valid && (addr1 != self_mac_addr)) begin
                        nav_state <= NAV_UPDATE;
                    end
                end
                NAV_UPDATE: begin
                    if (fcs_in_strobe) begin
                        nav_state <= NAV_IDLE;
                    end
                end
                default: nav_state <= NAV_IDLE;
            endcase
        end
    end

    // physical and virtual carrier sense combined
    assign ch_idle_final = ch_idle && (!nav_enable || (nav == '0));

endmodule

`default_nettype wire

// File: source/slot_randomizer.sv
// slot count is the low cw_exp bits of the LFSR, exponents above CSMA_CW_EXP_MAX are clamped
`timescale 1ns/1ps

`include "csma_settings.svh"

`default_nettype none

module slot_randomizer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                take_new_random,
    input  csma_pkg::cw_exp_t   cw_exp_used,
    output csma_pkg::slot_cnt_t slot_count
);

    import csma_pkg::*;

    logic [31:0]             lfsr;
    cw_exp_t                 cw_exp_clamped;
    logic [`CSMA_SLOTS_W:0]  mask_full;     // one bit wider for the shift

    // xnor form, taps 32/22/2/1
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= `CSMA_LFSR_INIT;
        end else if (take_new_random) begin
            lfsr <= {lfsr[30:0], ~^{lfsr[31], lfsr[21], lfsr[1:0]}};
        end
    end

    assign cw_exp_clamped = (cw_exp_used > cw_exp_t'(`CSMA_CW_EXP_MAX)) ?
                            cw_exp_t'(`CSMA_CW_EXP_MAX) : cw_exp_used;

    // 2^cw_exp - 1, zero when the exponent is zero
    assign mask_full = ({{`CSMA_SLOTS_W{1'b0}}, 1'b1} << cw_exp_clamped) - 1'b1;

    assign slot_count = lfsr[`CSMA_SLOTS_W-1:0] & mask_full[`CSMA_SLOTS_W-1:0];

endmodule

`default_nettype wire

// File: source/usec_countdown.sv
// load wins over count; the count sticks at zero and only moves on the 1 us pulse
`timescale 1ns/1ps

`default_nettype none

module usec_countdown #(
    parameter type count_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   tsf_pulse_1m,
    input  logic   load,
    input  count_t load_value,
    input  logic   enable,
    output count_t count,
    output logic   zero
);

    logic step;

    // decrement only on a microsecond tick, never below zero
    assign step = enable && tsf_pulse_1m && (count != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    assign zero = (count == '0);

endmodule

`default_nettype wire

// File: testbench/csma_ca_asserts.sv
// bound into csma_ca_top; relies on ch_idle_final and take_new_random being nets in that scope
`timescale 1ns/1ps

`default_nettype none

module csma_ca_asserts (
    input logic clk,
    input logic rstn,
    input logic backoff_done,
    input logic take_new_random,
    input logic ch_idle_final
);

    int unsigned fail_count = 0;   // read by the testbench at the end of the run

    // reset is synchronous, so look one cycle after rstn is sampled low
    reset_quiet: assert property (@(posedge clk) !rstn |=> !backoff_done)
        else begin
            fail_count++;
            $error("backoff_done high after a reset cycle");
        end

    rand_single: assert property (@(posedge clk) disable iff (!rstn)
                                  take_new_random |=> !take_new_random)
        else begin
            fail_count++;
            $error("take_new_random held for more than one cycle");
        end

    // never report the channel won while the medium is busy
    done_needs_idle: assert property (@(posedge clk) disable iff (!rstn)
                                      backoff_done |-> ch_idle_final)
        else begin
            fail_count++;
            $error("backoff_done high while ch_idle_final is low");
        end

endmodule

bind csma_ca_top csma_ca_asserts u_asserts (
    .clk(clk), .rstn(rstn), .backoff_done(backoff_done),
    .take_new_random(take_new_random), .ch_idle_final(ch_idle_final)
);

`default_nettype wire

// File: testbench/csma_ca_tb.sv
// directed tests only; one microsecond is four clocks here and window checks allow +-2 us
`timescale 1ns/1ps

`include "csma_settings.svh"

`default_nettype none

module csma_ca_tb;

    import csma_pkg::*;

    localparam int SLOT     = 9;
    localparam int SIFS     = 16;
    localparam int DIFS_ADV = 2;
    localparam int BO_ADV   = 3;
    localparam int DIFS     = SIFS + 2 * SLOT;
    localparam int EIFS     = SIFS + DIFS + `CSMA_LONGEST_ACK_US;
    localparam int TOL      = 2;        // in microsecond pulses
    localparam int TIMEOUT  = 40000;    // clocks per wait
    localparam mac_addr_t SELF_MAC  = 48'h02_11_22_33_44_55;
    localparam mac_addr_t OTHER_MAC = 48'h02_aa_bb_cc_dd_ee;

    logic        clk, rstn, tsf_pulse_1m;
    logic        pkt_header_valid, pkt_header_valid_strobe, fcs_in_strobe, fcs_valid;
    logic        nav_enable, difs_enable, eifs_enable;
    cw_exp_t     cw_exp_used;
    logic [4:0]  slot_time;
    logic [6:0]  sifs_time;
    logic [7:0]  difs_advance, backoff_advance;
    logic        addr1_valid, fc_di_valid;
    mac_addr_t   addr1, self_mac_addr;
    logic [15:0] duration;
    logic        ch_idle, retrans_trigger, quit_retrans, reset_backoff, high_trigger;
    logic        tx_bb_is_ongoing, ack_tx_flag;
    logic        backoff_done;
    cw_exp_t     cw_exp_log;
    slot_cnt_t   num_slot_random_log;
    logic [1:0]  tick_div;
    logic [31:0] rng;

    csma_ca_top uut (.*);

    always #20 clk = ~clk;

    // 1 us tick is one clock high out of four
    always @(posedge clk) begin
        tick_div     <= tick_div + 2'd1;
        tsf_pulse_1m <= (tick_div == 2'd3);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "value check failed");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s at %0d ns", what, $time);
        $display("TEST FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic check_window(input string what, input int got, input int expected);
        assert (got >= expected - TOL && got <= expected + TOL)
        else report_mismatch($sformatf("%s took %0d us, expected %0d", what, got, expected));
    endtask

    // counts pulses until backoff_done, sampled at the falling edge
    task automatic wait_for_done(output int pulses);
        int cycles;
        pulses = 0;
        cycles = 0;
        while (backoff_done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (tsf_pulse_1m) pulses++;
            if (cycles > TIMEOUT) report_timeout("backoff_done");
        end
    endtask

    task automatic watch_pulses(input int n, input bit keep_low);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n) begin
            @(negedge clk);
            cycles++;
            if (tsf_pulse_1m) seen++;
            if (keep_low) begin
                assert (backoff_done == 1'b0)
                else report_mismatch("backoff_done rose while it had to stay low");
            end
            if (cycles > TIMEOUT) report_timeout("microsecond pulses");
        end
    endtask

    task automatic fire_trigger(input bit retrans);
        @(posedge clk);
        high_trigger    <= !retrans;
        retrans_trigger <= retrans;
        @(posedge clk);
        high_trigger    <= 1'b0;
        retrans_trigger <= 1'b0;
    endtask

    // header, duration, receiver address, then FCS, one strobe per clock
    task automatic send_frame(input mac_addr_t ra, input logic [15:0] dur, input bit fcs_ok);
        @(posedge clk);
        pkt_header_valid_strobe <= 1'b1;
        pkt_header_valid        <= 1'b1;
        @(posedge clk);
        pkt_header_valid_strobe <= 1'b0;
        fc_di_valid             <= 1'b1;
        duration                <= dur;
        @(posedge clk);
        fc_di_valid <= 1'b0;
        addr1_valid <= 1'b1;
        addr1       <= ra;
        @(posedge clk);
        addr1_valid   <= 1'b0;
        fcs_in_strobe <= 1'b1;
        fcs_valid     <= fcs_ok;
        @(posedge clk);
        fcs_in_strobe <= 1'b0;
    endtask

    task automatic end_own_tx();
        @(posedge clk);
        tx_bb_is_ongoing <= 1'b1;
        ack_tx_flag      <= 1'b0;   // no ACK so no further backoff owed
        @(posedge clk);
        tx_bb_is_ongoing <= 1'b0;
        @(negedge clk);
        assert (backoff_done == 1'b0)
        else report_mismatch("backoff_done still high after own transmission started");
    endtask

    task automatic difs_after_good_frame();
        int pulses;
        send_frame(SELF_MAC, 16'd0, 1'b1);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        check_window("DIFS wait", pulses, DIFS - DIFS_ADV);
        end_own_tx();
    endtask

    task automatic eifs_after_bad_fcs();
        int pulses;
        send_frame(SELF_MAC, 16'd0, 1'b0);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        check_window("EIFS wait", pulses, EIFS - DIFS_ADV);
        end_own_tx();
    endtask

    task automatic retrans_random_window();
        cw_exp_t cw;
        int      pulses;
        int      expected;
        rng = xorshift32(rng);
        cw  = cw_exp_t'(1 + rng % 6);
        @(posedge clk);
        cw_exp_used <= cw;
        send_frame(SELF_MAC, 16'd0, 1'b1);
        fire_trigger(1'b1);
        wait_for_done(pulses);
        assert (cw_exp_log == cw)
        else report_mismatch($sformatf("cw_exp_log %0d, expected %0d", cw_exp_log, cw));
        assert (int'(num_slot_random_log) < (1 << cw))
        else report_mismatch($sformatf("slot count %0d outside window", num_slot_random_log));
        expected = DIFS - DIFS_ADV;
        if (num_slot_random_log != '0) begin
            expected += int'(num_slot_random_log) * SLOT - BO_ADV;
        end
        check_window("retransmit backoff", pulses, expected);
        end_own_tx();
    endtask

    task automatic nav_deferral();
        int          pulses;
        logic [15:0] dur;
        rng = xorshift32(rng);
        dur = 16'(60 + rng % 200);
        @(posedge clk);
        cw_exp_used <= cw_exp_t'(2);
        send_frame(OTHER_MAC, dur, 1'b1);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        assert (pulses >= int'(dur) - TOL)
        else report_mismatch($sformatf("done after %0d us inside NAV of %0d", pulses, dur));
        end_own_tx();
        send_frame(SELF_MAC, dur, 1'b1);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        check_window("frame to self", pulses, DIFS - DIFS_ADV);
        end_own_tx();
        @(posedge clk);
        nav_enable <= 1'b0;     // stays off while the next NAV drains in the background
        send_frame(OTHER_MAC, dur, 1'b1);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        check_window("NAV disabled", pulses, DIFS - DIFS_ADV);
        end_own_tx();
    endtask

    task automatic busy_during_run();
        int pulses;
        int run_us;
        int attempt;
        bit suspended;
        suspended = 1'b0;
        @(posedge clk);
        cw_exp_used <= cw_exp_t'(6);
        send_frame(SELF_MAC, 16'd0, 1'b1);
        for (attempt = 0; attempt < 4 && !suspended; attempt++) begin
            fire_trigger(1'b1);
            watch_pulses(DIFS - DIFS_ADV + 3, 1'b0);   // a few us into RUN
            if (num_slot_random_log >= 3) begin
                run_us = int'(num_slot_random_log) * SLOT - BO_ADV;
                @(posedge clk);
                ch_idle <= 1'b0;
                watch_pulses(30, 1'b1);
                @(posedge clk);
                ch_idle <= 1'b1;
                wait_for_done(pulses);
                // wait plus backoff without the busy time
                check_window("suspended backoff", DIFS - DIFS_ADV + 3 + pulses,
                             DIFS - DIFS_ADV + run_us);
                suspended = 1'b1;
            end else begin
                wait_for_done(pulses);
            end
            end_own_tx();
        end
        assert (suspended)
        else report_mismatch("no backoff was long enough to suspend");
    endtask

    task automatic abort_mid_wait();
        int pulses;
        fire_trigger(1'b0);
        watch_pulses(10, 1'b1);
        @(posedge clk);
        reset_backoff <= 1'b1;
        @(posedge clk);
        reset_backoff <= 1'b0;
        watch_pulses(2 * EIFS, 1'b1);
        send_frame(SELF_MAC, 16'd0, 1'b1);
        fire_trigger(1'b0);
        wait_for_done(pulses);
        check_window("trigger after abort", pulses, DIFS - DIFS_ADV);
        end_own_tx();
    endtask

    initial begin
        clk                     = 1'b0;
        rstn                    = 1'b0;
        tick_div                = 2'd0;
        tsf_pulse_1m            = 1'b0;
        pkt_header_valid        = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_valid               = 1'b0;
        nav_enable              = 1'b1;
        difs_enable             = 1'b1;
        eifs_enable             = 1'b1;
        cw_exp_used             = '0;
        slot_time               = 5'(SLOT);
        sifs_time               = 7'(SIFS);
        difs_advance            = 8'(DIFS_ADV);
        backoff_advance         = 8'(BO_ADV);
        addr1_valid             = 1'b0;
        addr1                   = '0;
        self_mac_addr           = SELF_MAC;
        fc_di_valid             = 1'b0;
        duration                = '0;
        ch_idle                 = 1'b1;
        retrans_trigger         = 1'b0;
        quit_retrans            = 1'b0;
        reset_backoff           = 1'b0;
        high_trigger            = 1'b0;
        tx_bb_is_ongoing        = 1'b0;
        ack_tx_flag             = 1'b0;
        rng                     = 32'hc4938a1e;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        difs_after_good_frame();
        eifs_after_bad_fcs();
        retrans_random_window();
        nav_deferral();
        busy_during_run();
        abort_mid_wait();
        if (uut.u_asserts.fail_count != 0) begin
            $display("concurrent assertions failed %0d times", uut.u_asserts.fail_count);
            $display("TEST FAILED");
            $fatal(1, "protocol assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/csma_pkg.sv
source/usec_countdown.sv
source/nav_tracker.sv
source/slot_randomizer.sv
source/backoff_ctrl.sv
source/csma_ca_top.sv
testbench/csma_ca_asserts.sv
testbench/csma_ca_tb.sv
